/* include/dcache_consts.svh */
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// core address and line geometry
`define DCACHE_ADDR_W 32
`define DCACHE_LINE_W 128

// two ways of sixteen sets
`define DCACHE_NSET 16
`define DCACHE_NWAY 2

// address splits into tag, index and byte offset
`define DCACHE_OFFSET_W 4
`define DCACHE_INDEX_W 4
`define DCACHE_TAG_W 24

`define DCACHE_WORDS 4

`endif

/* verilog/dcache_pkg.sv */
`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0] addr_t;
    typedef logic [`DCACHE_LINE_W/`DCACHE_WORDS-1:0] word_t;
    typedef logic [`DCACHE_LINE_W-1:0] line_t;
    typedef logic [`DCACHE_TAG_W-1:0] tag_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    // address of a whole line, offset bits dropped
    typedef logic [`DCACHE_ADDR_W-`DCACHE_OFFSET_W-1:0] line_addr_t;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } access_size_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_REQ,
        WB_RELEASE,
        FILL_REQ,
        FILL_RELEASE,
        FILL_WRITE
    } ctrl_state_t;

endpackage

/* verilog/dcache_way.sv */
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_way (
    input  logic               clk,
    input  logic               rst,

    // lookup
    input  dcache_pkg::index_t index_i,
    input  dcache_pkg::tag_t   tag_i,

    // line write at index_i
    input  logic               we_i,
    input  dcache_pkg::tag_t   wtag_i,
    input  dcache_pkg::line_t  wline_i,
    input  logic               wdirty_i,

    // stored entry at index_i
    output logic               hit_o,
    output logic               valid_o,
    output logic               dirty_o,
    output dcache_pkg::tag_t   tag_o,
    output dcache_pkg::line_t  line_o
);

    dcache_pkg::tag_t  tag_mem  [`DCACHE_NSET];
    dcache_pkg::line_t line_mem [`DCACHE_NSET];

    logic [`DCACHE_NSET-1:0] valid_r;
    logic [`DCACHE_NSET-1:0] dirty_r;

    // per-set status bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_r <= '0;
            dirty_r <= '0;
        end else if (we_i) begin
            valid_r[index_i] <= 1'b1;
            dirty_r[index_i] <= wdirty_i;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_mem[index_i]  <= wtag_i;
            line_mem[index_i] <= wline_i;
        end
    end

    // asynchronous read of the selected set
    assign valid_o = valid_r[index_i];
    assign dirty_o = dirty_r[index_i];
    assign tag_o   = tag_mem[index_i];
    assign line_o  = line_mem[index_i];

    // a hit needs a valid entry with a matching tag
    assign hit_o = valid_o && (tag_o == tag_i);

endmodule

/* verilog/dcache_store_merge.sv */
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_store_merge (
    input  dcache_pkg::line_t          line_i,
    input  logic [`DCACHE_OFFSET_W-1:0] offset_i,
    input  dcache_pkg::access_size_t   size_i,
    input  dcache_pkg::word_t          wdata_i,
    output dcache_pkg::line_t          line_o
);

    localparam int NBYTES = `DCACHE_LINE_W / 8;

    logic [NBYTES-1:0] byte_en;
    dcache_pkg::line_t wdata_rep;

    // each byte lane of the line sees the same lane of the store word
    assign wdata_rep = {`DCACHE_WORDS{wdata_i}};

    // byte enables with halfword and word aligned down
    always_comb begin
        case (size_i)
            dcache_pkg::SIZE_BYTE: byte_en = NBYTES'(1) << offset_i;
            dcache_pkg::SIZE_HALF: byte_en = NBYTES'(3) << {offset_i[`DCACHE_OFFSET_W-1:1], 1'b0};
            dcache_pkg::SIZE_WORD: byte_en = NBYTES'(15) << {offset_i[`DCACHE_OFFSET_W-1:2], 2'b00};
            default:               byte_en = '0;
        endcase
    end

    always_comb begin
        for (int b = 0; b < NBYTES; b++) begin
            if (byte_en[b]) begin
                line_o[b*8 +: 8] = wdata_rep[b*8 +: 8];
            end else begin
                line_o[b*8 +: 8] = line_i[b*8 +: 8];
            end
        end
    end

endmodule

/* verilog/dcache_ctrl.sv */
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_ctrl (
    input  logic                         clk,
    input  logic                         rst,

    // cpu side
    input  logic                         req_valid_i,
    input  logic                         req_we_i,
    input  dcache_pkg::access_size_t     req_size_i,
    input  dcache_pkg::addr_t            req_addr_i,
    input  dcache_pkg::word_t            req_wdata_i,
    output logic                         req_ready_o,
    output logic                         resp_valid_o,
    output dcache_pkg::word_t            resp_rdata_o,

    // memory line port
    output logic                         mem_req_o,
    output logic                         mem_we_o,
    output dcache_pkg::line_addr_t       mem_addr_o,
    output dcache_pkg::line_t            mem_wdata_o,
    input  logic                         mem_ack_i,
    input  dcache_pkg::line_t            mem_rdata_i,

    // way lookup
    output dcache_pkg::index_t           way_index_o,
    output dcache_pkg::tag_t             way_tag_o,
    input  logic [`DCACHE_NWAY-1:0]      way_hit_i,
    input  logic [`DCACHE_NWAY-1:0]      way_valid_i,
    input  logic [`DCACHE_NWAY-1:0]      way_dirty_i,
    input  dcache_pkg::tag_t             way_tag_i [`DCACHE_NWAY],
    input  dcache_pkg::line_t            way_line_i [`DCACHE_NWAY],

    // way write
    output logic [`DCACHE_NWAY-1:0]      way_we_o,
    output dcache_pkg::tag_t             way_wtag_o,
    output dcache_pkg::line_t            way_wline_o,
    output logic                         way_wdirty_o
);

    dcache_pkg::ctrl_state_t state, state_next;

    // registered request
    logic                     req_we_r;
    dcache_pkg::access_size_t req_size_r;
    dcache_pkg::addr_t        req_addr_r;
    dcache_pkg::word_t        req_wdata_r;

    dcache_pkg::index_t req_index;
    dcache_pkg::tag_t   req_tag;

    // lru_r[set] names the least recently used way of that set
    logic [`DCACHE_NSET-1:0] lru_r;

    logic              hit;
    logic              hit_way;
    dcache_pkg::line_t hit_line;
    dcache_pkg::line_t merged_line;
    dcache_pkg::line_t resp_line;
    logic              victim;
    logic              victim_r;
    dcache_pkg::line_t fill_line_r;

    assign req_index = req_addr_r[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign req_tag   = req_addr_r[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];

    assign way_index_o = req_index;
    assign way_tag_o   = req_tag;

    // combine the per-way hits
    always_comb begin
        hit      = 1'b0;
        hit_way  = 1'b0;
        hit_line = way_line_i[0];
        for (int w = 0; w < `DCACHE_NWAY; w++) begin
            if (way_hit_i[w]) begin
                hit      = 1'b1;
                hit_way  = w[0];
                hit_line = way_line_i[w];
            end
        end
    end

    // first invalid way wins, else the lru way
    always_comb begin
        victim = lru_r[req_index];
        if (!way_valid_i[1]) victim = 1'b1;
        if (!way_valid_i[0]) victim = 1'b0;
    end

    dcache_store_merge store_merge_inst (
        .line_i   (hit_line),
        .offset_i (req_addr_r[`DCACHE_OFFSET_W-1:0]),
        .size_i   (req_size_r),
        .wdata_i  (req_wdata_r),
        .line_o   (merged_line)
    );

    // a store answers with its own merged word
    assign resp_line    = req_we_r ? merged_line : hit_line;
    assign resp_rdata_o = resp_line[req_addr_r[`DCACHE_OFFSET_W-1:2]*32 +: 32];
    assign resp_valid_o = (state == dcache_pkg::LOOKUP) && hit;
    assign req_ready_o  = (state == dcache_pkg::IDLE);

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::IDLE: begin
                if (req_valid_i) state_next = dcache_pkg::LOOKUP;
            end
            dcache_pkg::LOOKUP: begin
                if (hit) begin
                    state_next = dcache_pkg::IDLE;
                end else if (way_valid_i[victim] && way_dirty_i[victim]) begin
                    state_next = dcache_pkg::WB_REQ;
                end else begin
                    state_next = dcache_pkg::FILL_REQ;
                end
            end
            dcache_pkg::WB_REQ: begin
                if (mem_ack_i) state_next = dcache_pkg::WB_RELEASE;
            end
            dcache_pkg::WB_RELEASE: begin
                if (!mem_ack_i) state_next = dcache_pkg::FILL_REQ;
            end
            dcache_pkg::FILL_REQ: begin
                if (mem_ack_i) state_next = dcache_pkg::FILL_RELEASE;
            end
            dcache_pkg::FILL_RELEASE: begin
                if (!mem_ack_i) state_next = dcache_pkg::FILL_WRITE;
            end
            // replay the access against the new line
            dcache_pkg::FILL_WRITE: state_next = dcache_pkg::LOOKUP;
            default: state_next = dcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::IDLE;
            lru_r <= '0;
        end else begin
            state <= state_next;
            if (state == dcache_pkg::LOOKUP && hit) lru_r[req_index] <= ~hit_way;
        end
    end

    always_ff @(posedge clk) begin
        if (state == dcache_pkg::IDLE && req_valid_i) begin
            req_we_r    <= req_we_i;
            req_size_r  <= req_size_i;
            req_addr_r  <= req_addr_i;
            req_wdata_r <= req_wdata_i;
        end
        if (state == dcache_pkg::LOOKUP) victim_r <= victim;
        if (state == dcache_pkg::FILL_REQ && mem_ack_i) fill_line_r <= mem_rdata_i;
    end

    // store hits mark the line dirty, refills land clean
    always_comb begin
        way_we_o     = '0;
        way_wtag_o   = req_tag;
        way_wline_o  = fill_line_r;
        way_wdirty_o = 1'b0;
        if (state == dcache_pkg::LOOKUP && hit && req_we_r) begin
            way_we_o[hit_way] = 1'b1;
            way_wline_o       = merged_line;
            way_wdirty_o      = 1'b1;
        end else if (state == dcache_pkg::FILL_WRITE) begin
            way_we_o[victim_r] = 1'b1;
        end
    end

    // victim tag and line stay put while the set is not written
    assign mem_req_o   = (state == dcache_pkg::WB_REQ) || (state == dcache_pkg::FILL_REQ);
    assign mem_we_o    = (state == dcache_pkg::WB_REQ);
    assign mem_wdata_o = way_line_i[victim_r];
    assign mem_addr_o  = (state == dcache_pkg::WB_REQ) ? {way_tag_i[victim_r], req_index}
                                                        : req_addr_r[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W];

endmodule

/* verilog/dcache_top.sv */
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_top (
    input  logic                     clk,
    input  logic                     rst,

    // cpu side
    input  logic                     req_valid_i,
    input  logic                     req_we_i,
    input  dcache_pkg::access_size_t req_size_i,
    input  dcache_pkg::addr_t        req_addr_i,
    input  dcache_pkg::word_t        req_wdata_i,
    output logic                     req_ready_o,
    output logic                     resp_valid_o,
    output dcache_pkg::word_t        resp_rdata_o,

    // memory line port
    output logic                     mem_req_o,
    output logic                     mem_we_o,
    output dcache_pkg::line_addr_t   mem_addr_o,
    output dcache_pkg::line_t        mem_wdata_o,
    input  logic                     mem_ack_i,
    input  dcache_pkg::line_t        mem_rdata_i
);

    dcache_pkg::index_t        way_index;
    dcache_pkg::tag_t          way_tag;
    logic [`DCACHE_NWAY-1:0]   way_hit;
    logic [`DCACHE_NWAY-1:0]   way_valid;
    logic [`DCACHE_NWAY-1:0]   way_dirty;
    dcache_pkg::tag_t          way_rtag [`DCACHE_NWAY];
    dcache_pkg::line_t         way_line [`DCACHE_NWAY];
    logic [`DCACHE_NWAY-1:0]   way_we;
    dcache_pkg::tag_t          way_wtag;
    dcache_pkg::line_t         way_wline;
    logic                      way_wdirty;

    // both ways share index, tag and write data
    for (genvar g = 0; g < `DCACHE_NWAY; g++) begin : gen_way
        dcache_way way_inst (
            .clk      (clk),
            .rst      (rst),
            .index_i  (way_index),
            .tag_i    (way_tag),
            .we_i     (way_we[g]),
            .wtag_i   (way_wtag),
            .wline_i  (way_wline),
            .wdirty_i (way_wdirty),
            .hit_o    (way_hit[g]),
            .valid_o  (way_valid[g]),
            .dirty_o  (way_dirty[g]),
            .tag_o    (way_rtag[g]),
            .line_o   (way_line[g])
        );
    end

    dcache_ctrl ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid_i),
        .req_we_i     (req_we_i),
        .req_size_i   (req_size_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i),
        .way_index_o  (way_index),
        .way_tag_o    (way_tag),
        .way_hit_i    (way_hit),
        .way_valid_i  (way_valid),
        .way_dirty_i  (way_dirty),
        .way_tag_i    (way_rtag),
        .way_line_i   (way_line),
        .way_we_o     (way_we),
        .way_wtag_o   (way_wtag),
        .way_wline_o  (way_wline),
        .way_wdirty_o (way_wdirty)
    );

endmodule

/* tb/tb_mem_model.sv */
`timescale 1ns/1ns

module tb_mem_model #(
    parameter logic [31:0] INIT_XOR = 32'h5a3c_96e1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_req_i,
    input  logic                   mem_we_i,
    input  dcache_pkg::line_addr_t mem_addr_i,
    input  dcache_pkg::line_t      mem_wdata_i,
    output logic                   mem_ack_o,
    output dcache_pkg::line_t      mem_rdata_o
);

    // lines that were never written keep their fill pattern
    dcache_pkg::line_t mem [dcache_pkg::line_addr_t];

    int                     read_count;
    int                     write_count;
    int                     stuck_count;
    dcache_pkg::line_addr_t last_wb_addr;
    dcache_pkg::line_t      last_wb_line;

    integer seed;
    int     delay;
    int     wait_cycles;

    // each word holds its own word address xor a constant
    function automatic dcache_pkg::line_t fill_pattern(dcache_pkg::line_addr_t la);
        dcache_pkg::line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = {2'b00, la, 2'(w)} ^ INIT_XOR;
        end
        return l;
    endfunction

    initial begin
        seed         = 32'hdec1_ea25;
        mem_ack_o    = 1'b0;
        mem_rdata_o  = '0;
        read_count   = 0;
        write_count  = 0;
        stuck_count  = 0;
        last_wb_addr = '0;
        last_wb_line = '0;
    end

    // four-phase responder driven on the falling edge
    always begin
        @(negedge clk);
        if (!rst && mem_req_i && !mem_ack_o) begin
            delay = $random(seed) & 3;
            repeat (delay) @(negedge clk);
            if (mem_we_i) begin
                mem[mem_addr_i] = mem_wdata_i;
                write_count++;
                last_wb_addr = mem_addr_i;
                last_wb_line = mem_wdata_i;
            end else begin
                mem_rdata_o = mem.exists(mem_addr_i) ? mem[mem_addr_i]
                                                     : fill_pattern(mem_addr_i);
                read_count++;
            end
            mem_ack_o = 1'b1;
            wait_cycles = 0;
            do begin
                @(negedge clk);
                wait_cycles++;
            end while (mem_req_i && wait_cycles < 100);
            if (mem_req_i) begin
                stuck_count++;
                $display("memory model: cache never released its request");
            end
            delay = $random(seed) & 3;
            repeat (delay) @(negedge clk);
            mem_ack_o = 1'b0;
        end
    end

endmodule

/* tb/tb_dcache_top.sv */
`timescale 1ns/1ns
`include "dcache_consts.svh"

module tb_dcache_top;

    localparam logic [31:0] INIT_XOR = 32'h5a3c_96e1;
    localparam int WAIT_LIMIT = 200;

    logic                     clk;
    logic                     rst;
    logic                     req_valid;
    logic                     req_we;
    dcache_pkg::access_size_t req_size;
    dcache_pkg::addr_t        req_addr;
    dcache_pkg::word_t        req_wdata;
    logic                     req_ready;
    logic                     resp_valid;
    dcache_pkg::word_t        resp_rdata;
    logic                     mem_req;
    logic                     mem_we;
    dcache_pkg::line_addr_t   mem_addr;
    dcache_pkg::line_t        mem_wdata;
    logic                     mem_ack;
    dcache_pkg::line_t        mem_rdata;

    int value_errors;
    int protocol_errors;
    int timeout_errors;

    // stimulus table with one entry per row in each queue
    string                    name_tab [$];
    logic                     we_tab [$];
    dcache_pkg::access_size_t size_tab [$];
    dcache_pkg::addr_t        addr_tab [$];
    dcache_pkg::word_t        wdata_tab [$];
    dcache_pkg::word_t        exp_tab [$];
    logic                     hit_tab [$];
    int                       reads_tab [$];
    int                       writes_tab [$];
    dcache_pkg::line_addr_t   wb_addr_tab [$];
    dcache_pkg::line_t        wb_line_tab [$];

    // shadow byte memory and tag model
    logic [7:0]        shadow [dcache_pkg::addr_t];
    dcache_pkg::tag_t  model_tag [`DCACHE_NSET][`DCACHE_NWAY];
    logic              model_valid [`DCACHE_NSET][`DCACHE_NWAY];
    logic              model_dirty [`DCACHE_NSET][`DCACHE_NWAY];
    logic              model_lru [`DCACHE_NSET];

    // protocol monitor state
    logic                   prev_mem_req;
    logic                   prev_mem_ack;
    logic                   prev_mem_we;
    dcache_pkg::line_addr_t prev_mem_addr;
    dcache_pkg::line_t      prev_mem_wdata;
    logic                   pending;
    int                     accepted;
    int                     responses;

    always #20 clk = ~clk;

    dcache_top dcache_top_inst (
        .clk          (clk),
        .rst          (rst),
        .req_valid_i  (req_valid),
        .req_we_i     (req_we),
        .req_size_i   (req_size),
        .req_addr_i   (req_addr),
        .req_wdata_i  (req_wdata),
        .req_ready_o  (req_ready),
        .resp_valid_o (resp_valid),
        .resp_rdata_o (resp_rdata),
        .mem_req_o    (mem_req),
        .mem_we_o     (mem_we),
        .mem_addr_o   (mem_addr),
        .mem_wdata_o  (mem_wdata),
        .mem_ack_i    (mem_ack),
        .mem_rdata_i  (mem_rdata)
    );

    tb_mem_model #(.INIT_XOR(INIT_XOR)) mem_model_inst (
        .clk         (clk),
        .rst         (rst),
        .mem_req_i   (mem_req),
        .mem_we_i    (mem_we),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_ack_o   (mem_ack),
        .mem_rdata_o (mem_rdata)
    );

    // untouched bytes come from the word address xor pattern
    function automatic logic [7:0] shadow_byte(dcache_pkg::addr_t a);
        logic [31:0] init_word;
        init_word = {2'b00, a[31:2]} ^ INIT_XOR;
        if (shadow.exists(a)) return shadow[a];
        return init_word[a[1:0]*8 +: 8];
    endfunction

    function automatic dcache_pkg::word_t shadow_word(dcache_pkg::addr_t a);
        dcache_pkg::word_t w;
        for (int k = 0; k < 4; k++) begin
            w[k*8 +: 8] = shadow_byte({a[31:2], 2'(k)});
        end
        return w;
    endfunction

    function automatic dcache_pkg::line_t shadow_line(dcache_pkg::line_addr_t la);
        dcache_pkg::line_t l;
        for (int k = 0; k < 16; k++) begin
            l[k*8 +: 8] = shadow_byte({la, 4'(k)});
        end
        return l;
    endfunction

    // halfword and word stores align down, lanes follow the byte address
    task automatic shadow_store(dcache_pkg::addr_t a, dcache_pkg::access_size_t size,
                                dcache_pkg::word_t wdata);
        dcache_pkg::addr_t base;
        dcache_pkg::addr_t b;
        int                n;
        case (size)
            dcache_pkg::SIZE_BYTE: begin
                base = a;
                n    = 1;
            end
            dcache_pkg::SIZE_HALF: begin
                base = {a[31:1], 1'b0};
                n    = 2;
            end
            default: begin
                base = {a[31:2], 2'b00};
                n    = 4;
            end
        endcase
        for (int k = 0; k < n; k++) begin
            b = base + dcache_pkg::addr_t'(k);
            shadow[b] = wdata[b[1:0]*8 +: 8];
        end
    endtask

    // predicts hit, victim, write-back and response for one row
    task automatic add_row(string name, logic we, dcache_pkg::access_size_t size,
                           dcache_pkg::addr_t a, dcache_pkg::word_t wdata);
        dcache_pkg::index_t     idx;
        dcache_pkg::tag_t       tag;
        int                     way;
        logic                   hit;
        int                     writes;
        dcache_pkg::line_addr_t wb_addr;
        dcache_pkg::line_t      wb_line;
        idx     = a[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
        tag     = a[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];
        hit     = 1'b0;
        way     = 0;
        writes  = 0;
        wb_addr = '0;
        wb_line = '0;
        for (int w = 0; w < `DCACHE_NWAY; w++) begin
            if (model_valid[idx][w] && model_tag[idx][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            if (!model_valid[idx][0]) way = 0;
            else if (!model_valid[idx][1]) way = 1;
            else way = model_lru[idx] ? 1 : 0;
            if (model_valid[idx][way] && model_dirty[idx][way]) begin
                writes  = 1;
                wb_addr = {model_tag[idx][way], idx};
                wb_line = shadow_line(wb_addr);
            end
            model_tag[idx][way]   = tag;
            model_valid[idx][way] = 1'b1;
            model_dirty[idx][way] = 1'b0;
        end
        // the other way becomes least recently used
        model_lru[idx] = (way == 0);
        if (we) begin
            shadow_store(a, size, wdata);
            model_dirty[idx][way] = 1'b1;
        end
        name_tab.push_back(name);
        we_tab.push_back(we);
        size_tab.push_back(size);
        addr_tab.push_back(a);
        wdata_tab.push_back(wdata);
        exp_tab.push_back(shadow_word(a));
        hit_tab.push_back(hit);
        reads_tab.push_back(hit ? 0 : 1);
        writes_tab.push_back(writes);
        wb_addr_tab.push_back(wb_addr);
        wb_line_tab.push_back(wb_line);
    endtask

    task automatic check_word(string name, dcache_pkg::word_t exp, dcache_pkg::word_t act);
        if (act !== exp) begin
            value_errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_line(string name, dcache_pkg::line_t exp, dcache_pkg::line_t act);
        if (act !== exp) begin
            value_errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_line_addr(string name, dcache_pkg::line_addr_t exp,
                                   dcache_pkg::line_addr_t act);
        if (act !== exp) begin
            value_errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            value_errors++;
            $display("error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            value_errors++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic finish_run();
        int total;
        total = value_errors + protocol_errors + timeout_errors
              + mem_model_inst.stuck_count;
        $display("errors: value %0d, protocol %0d, timeout %0d, memory %0d",
                 value_errors, protocol_errors, timeout_errors,
                 mem_model_inst.stuck_count);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // entered and left on a falling edge
    task automatic apply_row(int i);
        int cycles;
        int reads0;
        int writes0;
        reads0  = mem_model_inst.read_count;
        writes0 = mem_model_inst.write_count;
        cycles  = 0;
        while (!req_ready && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!req_ready) begin
            timeout_errors++;
            $display("timeout: cache never became ready for %s", name_tab[i]);
            return;
        end
        req_valid = 1'b1;
        req_we    = we_tab[i];
        req_size  = size_tab[i];
        req_addr  = addr_tab[i];
        req_wdata = wdata_tab[i];
        @(negedge clk);
        req_valid = 1'b0;
        cycles    = 1;
        while (!resp_valid && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!resp_valid) begin
            timeout_errors++;
            $display("timeout: no response for %s", name_tab[i]);
            return;
        end
        check_word(name_tab[i], exp_tab[i], resp_rdata);
        if (hit_tab[i]) check_count({name_tab[i], "_latency"}, 1, cycles);
        check_count({name_tab[i], "_reads"}, reads_tab[i],
                    mem_model_inst.read_count - reads0);
        check_count({name_tab[i], "_writes"}, writes_tab[i],
                    mem_model_inst.write_count - writes0);
        if (writes_tab[i] != 0) begin
            check_line_addr({name_tab[i], "_wb_addr"}, wb_addr_tab[i],
                            mem_model_inst.last_wb_addr);
            check_line({name_tab[i], "_wb_line"}, wb_line_tab[i],
                       mem_model_inst.last_wb_line);
        end
    endtask

    // each sample holds the values of the cycle that just ended
    always @(posedge clk) begin
        if (!rst) begin
            if (mem_req && !prev_mem_req && prev_mem_ack) begin
                protocol_errors++;
                $display("protocol: mem_req_o rose while mem_ack_i was high");
            end
            if (mem_req && prev_mem_req && (mem_we !== prev_mem_we ||
                    mem_addr !== prev_mem_addr || mem_wdata !== prev_mem_wdata)) begin
                protocol_errors++;
                $display("protocol: memory request changed while mem_req_o was high");
            end
            if (resp_valid) begin
                responses++;
                if (!pending) begin
                    protocol_errors++;
                    $display("protocol: response without an outstanding request");
                end
                pending = 1'b0;
            end
            if (req_valid && req_ready) begin
                accepted++;
                if (pending) begin
                    protocol_errors++;
                    $display("protocol: request accepted before the previous response");
                end
                pending = 1'b1;
            end
        end
        prev_mem_req   = mem_req;
        prev_mem_ack   = mem_ack;
        prev_mem_we    = mem_we;
        prev_mem_addr  = mem_addr;
        prev_mem_wdata = mem_wdata;
    end

    initial begin
        clk             = 1'b0;
        rst             = 1'b1;
        req_valid       = 1'b0;
        req_we          = 1'b0;
        req_size        = dcache_pkg::SIZE_WORD;
        req_addr        = '0;
        req_wdata       = '0;
        value_errors    = 0;
        protocol_errors = 0;
        timeout_errors  = 0;
        prev_mem_req    = 1'b0;
        prev_mem_ack    = 1'b0;
        prev_mem_we     = 1'b0;
        prev_mem_addr   = '0;
        prev_mem_wdata  = '0;
        pending         = 1'b0;
        accepted        = 0;
        responses       = 0;
        for (int s = 0; s < `DCACHE_NSET; s++) begin
            model_lru[s] = 1'b0;
            for (int w = 0; w < `DCACHE_NWAY; w++) begin
                model_tag[s][w]   = '0;
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
            end
        end

        // set 3 holds lines 0x1030, 0x2030 and 0x3030, set 5 holds 0x4050
        add_row("cold_load", 1'b0, dcache_pkg::SIZE_WORD, 32'h0000_1034, '0);
        add_row("repeat_load", 1'b0, dcache_pkg::SIZE_WORD, 32'h0000_1034, '0);
        add_row("store_byte", 1'b1, dcache_pkg::SIZE_BYTE, 32'h0000_1035, 32'h0000_ab00);
        add_row("store_half", 1'b1, dcache_pkg::SIZE_HALF, 32'h0000_103a, 32'hcdef_0000);
        add_row("store_word", 1'b1, dcache_pkg::SIZE_WORD, 32'h0000_1030, 32'h1234_5678);
        add_row("load_byte_merge", 1'b0, dcache_pkg::SIZE_WORD, 32'h0000_1034, '0);
        add_row("load_half_merge", 1'b0, dcache_pkg::SIZE_HALF, 32'h0000_1038, '0);
        add_row("store_miss", 1'b1, dcache_pkg::SIZE_WORD, 32'h0000_2038, 32'hdead_beef);
        add_row("load_store_miss", 1'b0, dcache_pkg::SIZE_WORD, 32'h0000_2038, '0);
        add_row("evict_dirty_lru", 1'b0, dcache_pkg::SIZE_WORD, 32'h0000_303c, '0);
        add_row("reload_evicted", 1'b0, dcache_pkg::SIZE_WORD, 32'h0000_1034, '0);
        add_row("store_half_unaligned", 1'b1, dcache_pkg::SIZE_HALF, 32'h0000_4053,
                32'h1111_2222);
        add_row("load_unaligned_merge", 1'b0, dcache_pkg::SIZE_BYTE, 32'h0000_4050, '0);
        add_row("evict_clean", 1'b0, dcache_pkg::SIZE_WORD, 32'h0000_2038, '0);
        add_row("store_after_refetch", 1'b1, dcache_pkg::SIZE_BYTE, 32'h0000_2032,
                32'h0077_0000);
        add_row("evict_refetched", 1'b0, dcache_pkg::SIZE_WORD, 32'h0000_3030, '0);

        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_flag("reset_ready", 1'b1, req_ready);
        check_flag("reset_resp_valid", 1'b0, resp_valid);
        check_flag("reset_mem_req", 1'b0, mem_req);

        // a timeout stops the table early
        for (int i = 0; i < name_tab.size() && timeout_errors == 0; i++) begin
            apply_row(i);
        end

        repeat (2) @(negedge clk);
        check_count("responses", accepted, responses);
        check_count("requests", name_tab.size(), accepted);
        finish_run();
    end

endmodule

/* dcache_top.f */
+incdir+include
verilog/dcache_pkg.sv
verilog/dcache_way.sv
verilog/dcache_store_merge.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tb/tb_mem_model.sv
tb/tb_dcache_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_dcache_top \
    -Mdir obj_dir -f dcache_top.f
if [ $? -ne 0 ]; then
    echo "run_sim: verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dcache_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "run_sim: simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    echo "run_sim: failures reported in sim.log"
    exit 1
fi

echo "run_sim: no failures reported"
exit 0
